// ==== tb.f ====
hdl/ex_pkg.sv
hdl/ex_op_if.sv
hdl/ex_alu.sv
hdl/ex_divider.sv
hdl/ex_credit_counter.sv
hdl/ex_stage.sv
bench/ex_stage_assert.sv
bench/tb_ex_stage.sv

// ==== Makefile ====
TOP := tb_ex_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== bench/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    localparam int              XLEN        = ex_pkg::XLEN;
    localparam int              RES_CREDITS = 2;
    localparam logic [XLEN-1:0] MIN64       = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] ONES        = '1;

    typedef struct {
        ex_pkg::alu_op_e    op;
        logic [XLEN-1:0]    op1;
        logic [XLEN-1:0]    op2;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    wdata;
        logic               jump;
        logic [XLEN-1:0]    addr;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    ex_pkg::alu_op_e    in_op;
    logic [XLEN-1:0]    in_pc;
    logic [XLEN-1:0]    in_op1;
    logic [XLEN-1:0]    in_op2;
    logic [XLEN-1:0]    in_imm;
    logic [4:0]         in_rd;
    logic               res_credit;
    logic               in_credit;
    logic               out_valid;
    logic [XLEN-1:0]    out_wdata;
    logic [4:0]         out_rd;
    logic               out_jump;
    logic [XLEN-1:0]    out_jump_addr;

    row_t               tbl[$];
    int                 pend_q[$];
    logic [31:0]        rng;
    int                 cyc;
    int                 due_cyc;
    int                 owed;          // Results sent but not yet credited back.
    int                 credit_model;  // Free result credits as the DUT should see them.
    logic               credit_drv;
    logic               issue_credit;
    int                 hold_cyc;
    int                 delay_cyc;
    int                 sent_cnt;
    int                 credit_cnt;

    ex_stage #(
        .RES_CREDITS (RES_CREDITS)
    ) i_dut (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .in_valid_i      (in_valid),
        .in_op_i         (in_op),
        .in_pc_i         (in_pc),
        .in_op1_i        (in_op1),
        .in_op2_i        (in_op2),
        .in_imm_i        (in_imm),
        .in_rd_i         (in_rd),
        .res_credit_i    (res_credit),
        .in_credit_o     (in_credit),
        .out_valid_o     (out_valid),
        .out_wdata_o     (out_wdata),
        .out_rd_o        (out_rd),
        .out_jump_o      (out_jump),
        .out_jump_addr_o (out_jump_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    // Expected values from the ISA rules for a row.
    function automatic row_t model_row(input ex_pkg::alu_op_e op, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc);
        row_t                   r;
        logic [5:0]             sh;
        logic                   ovf;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic [XLEN-1:0]        uq;
        logic [XLEN-1:0]        ur;
        r.op    = op;
        r.op1   = a;
        r.op2   = b;
        r.imm   = imm;
        r.pc    = pc;
        r.wdata = '0;
        r.jump  = 1'b0;
        r.addr  = pc + 4;
        sh      = b[5:0];
        ovf     = a == MIN64 && b == ONES;
        sq      = '0;
        sr      = '0;
        uq      = '0;
        ur      = '0;
        if (b != '0 && !ovf) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        if (b != '0) begin
            uq = a / b;
            ur = a % b;
        end
        case (op)
            ex_pkg::ALU_ADD:  r.wdata = a + b;
            ex_pkg::ALU_SUB:  r.wdata = a - b;
            ex_pkg::ALU_AND:  r.wdata = a & b;
            ex_pkg::ALU_OR:   r.wdata = a | b;
            ex_pkg::ALU_XOR:  r.wdata = a ^ b;
            ex_pkg::ALU_SLT:  r.wdata = {63'b0, $signed(a) < $signed(b)};
            ex_pkg::ALU_SLTU: r.wdata = {63'b0, a < b};
            ex_pkg::ALU_SLL:  r.wdata = a << sh;
            ex_pkg::ALU_SRL:  r.wdata = a >> sh;
            ex_pkg::ALU_SRA:  r.wdata = $signed(a) >>> sh;
            ex_pkg::ALU_ADDW: r.wdata = $signed(a[31:0] + b[31:0]);  // Word sign-extends.
            ex_pkg::ALU_SUBW: r.wdata = $signed(a[31:0] - b[31:0]);
            ex_pkg::ALU_BEQ:  r.jump = a == b;
            ex_pkg::ALU_BNE:  r.jump = a != b;
            ex_pkg::ALU_BLT:  r.jump = $signed(a) < $signed(b);
            ex_pkg::ALU_BGE:  r.jump = $signed(a) >= $signed(b);
            ex_pkg::ALU_BLTU: r.jump = a < b;
            ex_pkg::ALU_BGEU: r.jump = a >= b;
            ex_pkg::ALU_JAL, ex_pkg::ALU_JALR: begin
                r.wdata = pc + 4;
                r.jump  = 1'b1;
            end
            ex_pkg::ALU_DIV:  r.wdata = (b == '0) ? ONES : (ovf ? a : sq);
            ex_pkg::ALU_DIVU: r.wdata = (b == '0) ? ONES : uq;
            ex_pkg::ALU_REM:  r.wdata = (b == '0) ? a : sr;
            ex_pkg::ALU_REMU: r.wdata = (b == '0) ? a : ur;
            default:          r.wdata = '0;
        endcase
        if (op == ex_pkg::ALU_JALR) begin
            r.addr = (a + imm) & ~64'd1;
        end else if (r.jump) begin
            r.addr = pc + imm;
        end
        return r;
    endfunction

    task automatic add_row(input ex_pkg::alu_op_e op, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
            input logic [XLEN-1:0] wdata, input logic jump, input logic [XLEN-1:0] addr);
        row_t r;
        r = '{op, a, b, imm, pc, wdata, jump, addr};
        tbl.push_back(r);
    endtask

    task automatic build_table();
        int                 pass;
        int                 k;
        int                 i;
        logic [31:0]        r;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        // Corner rows with hand-worked results. The first three are single-cycle.
        add_row(ex_pkg::ALU_SLL,  1, 63, 0, 'h40, MIN64, 0, 'h44);
        add_row(ex_pkg::ALU_SRA,  MIN64, 63, 0, 'h40, ONES, 0, 'h44);
        add_row(ex_pkg::ALU_SRL,  MIN64, 63, 0, 'h40, 1, 0, 'h44);
        add_row(ex_pkg::ALU_ADDW, 'h7fff_ffff, 1, 0, 'h40, 64'hffff_ffff_8000_0000, 0, 'h44);
        add_row(ex_pkg::ALU_SUBW, 0, 1, 0, 'h40, ONES, 0, 'h44);
        add_row(ex_pkg::ALU_BEQ,  5, 5, 'h10, 'h100, 0, 1, 'h110);
        add_row(ex_pkg::ALU_BGE,  ONES, 0, 'h10, 'h100, 0, 0, 'h104);
        add_row(ex_pkg::ALU_BLTU, 1, ONES, -64'd8, 'h100, 0, 1, 'hf8);
        add_row(ex_pkg::ALU_JAL,  0, 0, -64'd8, 'h300, 'h304, 1, 'h2f8);
        add_row(ex_pkg::ALU_JALR, 'h1001, 0, 2, 'h200, 'h204, 1, 'h1002);
        add_row(ex_pkg::ALU_DIV,  MIN64, ONES, 0, 'h40, MIN64, 0, 'h44);
        add_row(ex_pkg::ALU_REM,  MIN64, ONES, 0, 'h40, 0, 0, 'h44);
        add_row(ex_pkg::ALU_DIVU, 'h1234, 0, 0, 'h40, ONES, 0, 'h44);
        add_row(ex_pkg::ALU_REM,  -64'd5, 0, 0, 'h40, -64'd5, 0, 'h44);
        add_row(ex_pkg::ALU_DIV,  -64'd7, 2, 0, 'h40, -64'd3, 0, 'h44);
        for (pass = 0; pass < 2; pass++) begin
            for (k = int'(ex_pkg::ALU_ADD); k <= int'(ex_pkg::ALU_JALR); k++) begin
                r = xorshift();
                a = {xorshift(), xorshift()};
                b = (pass == 1) ? a : {xorshift(), xorshift()};  // Equal operands.
                tbl.push_back(model_row(ex_pkg::alu_op_e'(k), a, b,
                    {{51{r[12]}}, r[12:1], 1'b0}, {32'h0, xorshift() & 32'hffff_fffc}));
            end
        end
        for (i = 0; i < 6; i++) begin
            for (k = int'(ex_pkg::ALU_DIV); k <= int'(ex_pkg::ALU_REMU); k++) begin
                a = {xorshift(), xorshift()};
                b = {xorshift(), xorshift()} >> (xorshift() % 64);
                tbl.push_back(model_row(ex_pkg::alu_op_e'(k), a, b, 0, 'h40));
            end
        end
    endtask

    task automatic observe();
        int idx;
        check_value("in_credit_o", in_credit, out_valid);
        if (due_cyc == cyc && credit_model > 0) begin
            check_value("out_valid_o latency", out_valid, 1'b1);
        end
        if (out_valid && pend_q.size() == 0) begin
            abort_run("A result was sent while no instruction was in flight.");
        end else if (out_valid) begin
            idx = pend_q.pop_front();
            check_value($sformatf("row %0d wdata", idx), out_wdata, tbl[idx].wdata);
            check_value($sformatf("row %0d jump", idx), out_jump, tbl[idx].jump);
            check_value($sformatf("row %0d target", idx), out_jump_addr, tbl[idx].addr);
            check_value($sformatf("row %0d rd", idx), out_rd, idx % 32);
            check_value("result credit free", credit_model > 0, 1'b1);
            owed++;
            sent_cnt++;
            check_value("results outstanding", owed <= RES_CREDITS, 1'b1);
        end
        if (in_credit) begin
            credit_cnt++;
            issue_credit = 1'b1;
        end
        credit_model = credit_model + int'(credit_drv) - int'(out_valid);
    endtask

    // Consumer side, returns credits after a random delay.
    task automatic return_credits();
        credit_drv = 1'b0;
        if (hold_cyc > 0) begin
            hold_cyc--;
            if (hold_cyc == 0) begin
                check_value("results sent while credits held", owed, RES_CREDITS);
            end
        end else if (owed > 0 && delay_cyc > 0) begin
            delay_cyc--;
        end else if (owed > 0) begin
            credit_drv = 1'b1;
            owed--;
            delay_cyc  = xorshift() % 4;
        end
        res_credit <= credit_drv;
    endtask

    task automatic step();
        @(posedge clk);
        in_valid <= 1'b0;
        cyc++;
        observe();
        return_credits();
    endtask

    task automatic issue_row(input int n);
        in_valid     <= 1'b1;
        in_op        <= tbl[n].op;
        in_pc        <= tbl[n].pc;
        in_op1       <= tbl[n].op1;
        in_op2       <= tbl[n].op2;
        in_imm       <= tbl[n].imm;
        in_rd        <= 5'(n % 32);
        issue_credit = 1'b0;
        pend_q.push_back(n);
        if (tbl[n].op inside {ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU, ex_pkg::ALU_REM,
                              ex_pkg::ALU_REMU}) begin
            due_cyc = -1;
        end else begin
            due_cyc = cyc + 3;  // Accepted next edge, sent one cycle after the result.
        end
        if (n == 0) begin
            hold_cyc = 30;
        end
    endtask

    initial begin
        int n;
        int wait_cyc;
        rng          = 32'h78bb;
        cyc          = 0;
        due_cyc      = -1;
        owed         = 0;
        credit_model = RES_CREDITS;
        credit_drv   = 1'b0;
        issue_credit = 1'b1;
        hold_cyc     = 0;
        delay_cyc    = 0;
        sent_cnt     = 0;
        credit_cnt   = 0;
        rst_n      <= 1'b0;
        in_valid   <= 1'b0;
        in_op      <= ex_pkg::ALU_ADD;
        in_pc      <= '0;
        in_op1     <= '0;
        in_op2     <= '0;
        in_imm     <= '0;
        in_rd      <= '0;
        res_credit <= 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) step();  // Outputs must stay quiet before the first issue.
        for (n = 0; n < tbl.size(); n++) begin
            wait_cyc = 0;
            while (!issue_credit) begin
                step();
                wait_cyc++;
                if (wait_cyc > 300) begin
                    abort_run($sformatf("Timed out waiting for the issue credit for row %0d.", n));
                end
            end
            issue_row(n);
        end
        wait_cyc = 0;
        while (sent_cnt < tbl.size()) begin
            step();
            wait_cyc++;
            if (wait_cyc > 300) begin
                abort_run("Timed out waiting for the last results.");
            end
        end
        if (credit_cnt == sent_cnt && pend_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("The issue credit count does not match the results sent.");
        end
    end

endmodule

`default_nettype wire

// ==== bench/ex_stage_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assert #(
    parameter int RES_CREDITS = 2
) (
    input wire clk,
    input wire rst_n_i,
    input wire in_valid_i,
    input wire res_credit_i,
    input wire out_valid_i,
    input wire in_credit_i
);

    int     credits_q;    // Free result credits as seen from the ports.
    logic   in_flight_q;  // Accepted instruction whose result has not left.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credits_q   <= RES_CREDITS;
            in_flight_q <= 1'b0;
        end else begin
            credits_q <= credits_q + int'(res_credit_i) - int'(out_valid_i);
            if (in_valid_i) begin
                in_flight_q <= 1'b1;
            end else if (out_valid_i) begin
                in_flight_q <= 1'b0;
            end
        end
    end

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i |-> credits_q > 0)
        else $error("out_valid_o high while no result credit is free.");

    a_issue_credit_on_send: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_credit_i |-> out_valid_i && in_flight_q)
        else $error("in_credit_o pulsed without a result being sent.");

    // First cycle out of reset.
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !out_valid_i && !in_credit_i)
        else $error("Handshake outputs active in the first cycle after reset.");

endmodule

bind ex_stage ex_stage_assert #(
    .RES_CREDITS (RES_CREDITS)
) i_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .res_credit_i (res_credit_i),
    .out_valid_i  (out_valid_o),
    .in_credit_i  (in_credit_o)
);

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
    parameter int RES_CREDITS = 2
) (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  wire                                 in_valid_i,
    input  var ex_pkg::alu_op_e                 in_op_i,
    input  wire [ex_pkg::XLEN-1:0]              in_pc_i,
    input  wire [ex_pkg::XLEN-1:0]              in_op1_i,
    input  wire [ex_pkg::XLEN-1:0]              in_op2_i,
    input  wire [ex_pkg::XLEN-1:0]              in_imm_i,
    input  wire [ex_pkg::REG_ADDR_W-1:0]        in_rd_i,
    input  wire                                 res_credit_i,
    output logic                                in_credit_o,
    output logic                                out_valid_o,
    output logic [ex_pkg::XLEN-1:0]             out_wdata_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]       out_rd_o,
    output logic                                out_jump_o,
    output logic [ex_pkg::XLEN-1:0]             out_jump_addr_o
);

    localparam int XLEN = ex_pkg::XLEN;

    ex_op_if op_bus ();

    logic                           alu_pend_q;
    logic                           div_start_q;
    logic                           res_valid_q;
    logic [ex_pkg::REG_ADDR_W-1:0]  rd_q;
    logic [XLEN-1:0]                res_wdata_q;
    logic [ex_pkg::REG_ADDR_W-1:0]  res_rd_q;
    logic                           res_jump_q;
    logic [XLEN-1:0]                res_jump_addr_q;

    logic [XLEN-1:0]                alu_wdata;
    logic                           alu_jump;
    logic [XLEN-1:0]                alu_jump_addr;
    logic                           div_done;
    logic [XLEN-1:0]                div_result;
    logic                           can_send;
    logic                           capture;
    logic                           send;

    ex_alu u_alu (
        .op_bus      (op_bus),
        .wdata_o     (alu_wdata),
        .jump_o      (alu_jump),
        .jump_addr_o (alu_jump_addr)
    );

    ex_divider u_divider (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .start_i  (div_start_q),
        .op_bus   (op_bus),
        .done_o   (div_done),
        .result_o (div_result)
    );

    ex_credit_counter #(
        .RES_CREDITS (RES_CREDITS)
    ) u_credit (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .send_i     (send),
        .credit_i   (res_credit_i),
        .can_send_o (can_send)
    );

    // Issue register, reloaded only after the previous result has left.
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            op_bus.op  <= in_op_i;
            op_bus.pc  <= in_pc_i;
            op_bus.op1 <= in_op1_i;
            op_bus.op2 <= in_op2_i;
            op_bus.imm <= in_imm_i;
            rd_q       <= in_rd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_pend_q  <= 1'b0;
            div_start_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            alu_pend_q  <= in_valid_i & !ex_pkg::is_div_op(in_op_i);
            div_start_q <= in_valid_i & ex_pkg::is_div_op(in_op_i);  // One-cycle start pulse.
            if (capture) begin
                res_valid_q <= 1'b1;
            end else if (send) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    assign capture = alu_pend_q | div_done;

    // Output register holds the result until a credit lets it go.
    always_ff @(posedge clk) begin
        if (capture) begin
            res_wdata_q     <= div_done ? div_result : alu_wdata;
            res_rd_q        <= rd_q;
            res_jump_q      <= alu_jump;
            res_jump_addr_q <= alu_jump_addr;
        end
    end

    assign send            = res_valid_q & can_send;
    assign out_valid_o     = send;
    assign in_credit_o     = send;  // Issue slot frees as the result leaves.
    assign out_wdata_o     = res_wdata_q;
    assign out_rd_o        = res_rd_q;
    assign out_jump_o      = res_jump_q;
    assign out_jump_addr_o = res_jump_addr_q;

endmodule

`default_nettype wire

// ==== hdl/ex_credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_credit_counter #(
    parameter int RES_CREDITS = 2
) (
    input  wire     clk,
    input  wire     rst_n_i,
    input  wire     send_i,
    input  wire     credit_i,
    output logic    can_send_o
);

    localparam int                  CNT_W   = $clog2(RES_CREDITS + 1);
    localparam logic [CNT_W-1:0]    CNT_MAX = CNT_W'(RES_CREDITS);

    logic [CNT_W-1:0]   count_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= CNT_MAX;
        end else if (send_i && !credit_i && count_q != '0) begin
            count_q <= count_q - 1'b1;
        end else if (credit_i && !send_i && count_q != CNT_MAX) begin
            count_q <= count_q + 1'b1;  // Saturates at the reset value.
        end
    end

    assign can_send_o = count_q != '0;

endmodule

`default_nettype wire

// ==== hdl/ex_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_divider (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         start_i,
    ex_op_if.div                        op_bus,
    output logic                        done_o,
    output logic [ex_pkg::XLEN-1:0]     result_o
);

    localparam int XLEN  = ex_pkg::XLEN;
    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } div_state_e;

    div_state_e         state_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [XLEN-1:0]    quo_q;
    logic [XLEN-1:0]    rem_q;
    logic [XLEN-1:0]    dvs_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    logic               want_rem_q;
    logic               zero_dvs_q;

    logic               is_signed;
    logic               op1_neg;
    logic               op2_neg;
    logic [XLEN-1:0]    op1_mag;
    logic [XLEN-1:0]    op2_mag;
    logic [XLEN:0]      shifted;
    logic               fits;
    logic [XLEN-1:0]    quo_fix;
    logic [XLEN-1:0]    rem_fix;

    assign is_signed = op_bus.op inside {ex_pkg::ALU_DIV, ex_pkg::ALU_REM};
    assign op1_neg   = is_signed & op_bus.op1[XLEN-1];
    assign op2_neg   = is_signed & op_bus.op2[XLEN-1];
    // The most negative value keeps its bit pattern, which is its magnitude unsigned.
    assign op1_mag   = op1_neg ? -op_bus.op1 : op_bus.op1;
    assign op2_mag   = op2_neg ? -op_bus.op2 : op_bus.op2;

    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign fits    = shifted >= {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= BUSY;
                        cnt_q   <= CNT_W'(XLEN - 1);
                    end
                end
                BUSY: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;  // DONE lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            quo_q      <= op1_mag;
            rem_q      <= '0;
            dvs_q      <= op2_mag;
            neg_quo_q  <= op1_neg ^ op2_neg;
            neg_rem_q  <= op1_neg;  // Remainder takes the dividend's sign.
            want_rem_q <= op_bus.op inside {ex_pkg::ALU_REM, ex_pkg::ALU_REMU};
            zero_dvs_q <= op_bus.op2 == '0;
        end else if (state_q == BUSY) begin
            quo_q <= {quo_q[XLEN-2:0], fits};
            rem_q <= fits ? shifted[XLEN-1:0] - dvs_q : shifted[XLEN-1:0];
        end
    end

    // A zero divisor leaves the dividend magnitude in rem_q.
    assign quo_fix  = zero_dvs_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;
    assign result_o = want_rem_q ? rem_fix : quo_fix;
    assign done_o   = state_q == DONE;

endmodule

`default_nettype wire

// ==== hdl/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    ex_op_if.alu                        op_bus,
    output logic [ex_pkg::XLEN-1:0]     wdata_o,
    output logic                        jump_o,
    output logic [ex_pkg::XLEN-1:0]     jump_addr_o
);

    localparam int XLEN = ex_pkg::XLEN;

    logic [XLEN-1:0]    pc_plus4;
    logic [XLEN-1:0]    pc_imm;
    logic [XLEN-1:0]    jalr_sum;
    logic [31:0]        sum_w;
    logic [31:0]        diff_w;
    logic [5:0]         shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               taken;

    assign pc_plus4 = op_bus.pc + XLEN'(4);
    assign pc_imm   = op_bus.pc + op_bus.imm;
    assign jalr_sum = op_bus.op1 + op_bus.imm;
    assign sum_w    = op_bus.op1[31:0] + op_bus.op2[31:0];
    assign diff_w   = op_bus.op1[31:0] - op_bus.op2[31:0];
    assign shamt    = op_bus.op2[5:0];
    assign eq       = op_bus.op1 == op_bus.op2;
    assign lt_s     = $signed(op_bus.op1) < $signed(op_bus.op2);
    assign lt_u     = op_bus.op1 < op_bus.op2;

    always_comb begin
        wdata_o     = '0;
        jump_o      = 1'b0;
        jump_addr_o = pc_plus4;
        taken       = 1'b0;
        case (op_bus.op)
            ex_pkg::ALU_ADD:  wdata_o = op_bus.op1 + op_bus.op2;
            ex_pkg::ALU_SUB:  wdata_o = op_bus.op1 - op_bus.op2;
            ex_pkg::ALU_AND:  wdata_o = op_bus.op1 & op_bus.op2;
            ex_pkg::ALU_OR:   wdata_o = op_bus.op1 | op_bus.op2;
            ex_pkg::ALU_XOR:  wdata_o = op_bus.op1 ^ op_bus.op2;
            ex_pkg::ALU_SLT:  wdata_o = {{(XLEN-1){1'b0}}, lt_s};
            ex_pkg::ALU_SLTU: wdata_o = {{(XLEN-1){1'b0}}, lt_u};
            ex_pkg::ALU_SLL:  wdata_o = op_bus.op1 << shamt;
            ex_pkg::ALU_SRL:  wdata_o = op_bus.op1 >> shamt;
            ex_pkg::ALU_SRA:  wdata_o = $signed(op_bus.op1) >>> shamt;
            ex_pkg::ALU_ADDW: wdata_o = {{(XLEN-32){sum_w[31]}}, sum_w};  // Sign-extend word.
            ex_pkg::ALU_SUBW: wdata_o = {{(XLEN-32){diff_w[31]}}, diff_w};
            ex_pkg::ALU_BEQ:  taken = eq;
            ex_pkg::ALU_BNE:  taken = !eq;
            ex_pkg::ALU_BLT:  taken = lt_s;
            ex_pkg::ALU_BGE:  taken = !lt_s;
            ex_pkg::ALU_BLTU: taken = lt_u;
            ex_pkg::ALU_BGEU: taken = !lt_u;
            ex_pkg::ALU_JAL: begin
                wdata_o     = pc_plus4;
                jump_o      = 1'b1;
                jump_addr_o = pc_imm;
            end
            ex_pkg::ALU_JALR: begin
                wdata_o     = pc_plus4;
                jump_o      = 1'b1;
                jump_addr_o = {jalr_sum[XLEN-1:1], 1'b0};  // Bit 0 cleared.
            end
            default: wdata_o = '0;  // Divide results come from the divider.
        endcase

        if (ex_pkg::is_branch_op(op_bus.op)) begin
            jump_o      = taken;
            jump_addr_o = taken ? pc_imm : pc_plus4;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ex_op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ex_op_if;

    ex_pkg::alu_op_e            op;
    logic [ex_pkg::XLEN-1:0]    pc;
    logic [ex_pkg::XLEN-1:0]    op1;
    logic [ex_pkg::XLEN-1:0]    op2;
    logic [ex_pkg::XLEN-1:0]    imm;  // Branch and jump offset.

    modport issue (output op, output pc, output op1, output op2, output imm);

    modport alu (input op, input pc, input op1, input op2, input imm);

    modport div (input op, input op1, input op2);

endinterface

`default_nettype wire

// ==== hdl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 64; // W operations depend on this width.
    localparam int REG_ADDR_W = 5;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADDW,
        ALU_SUBW,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_JAL,
        ALU_JALR,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alu_op_e;

    // Divide operations go to the iterative divider.
    function automatic logic is_div_op(input alu_op_e op);
        return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

    function automatic logic is_branch_op(input alu_op_e op);
        return op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
    endfunction

endpackage

`default_nettype wire
